// ==== verilog/obj_config.svh ====
//********************
// sprite engine sizes and limits
// shared by the scan, queue, draw and line buffer blocks
//********************
`ifndef OBJ_CONFIG_SVH
`define OBJ_CONFIG_SVH

`define OBJ_SPRITES     64    // entries in sprite RAM
`define OBJ_PRIORITIES  16    // priority buckets
`define OBJ_LINE_W      320   // visible pixels per line
`define OBJ_BUF_DEPTH   512   // entries per line buffer bank

// graphics ROM layout
`define OBJ_SLICE_PIX   8     // 4-bit pixels per 32-bit slice
`define OBJ_ROW_BYTES   4     // one pixel row inside a tile
`define OBJ_TILE_BYTES  32    // one 8x8 tile

`endif

// ==== verilog/obj_pkg.sv ====
//********************
// sprite engine types
// field widths and state encodings
//********************
package obj_pkg;

    typedef logic [5:0]  spr_idx_t;    // sprite number
    typedef logic [3:0]  pri_t;
    typedef logic [8:0]  pos_t;        // line or x position
    typedef logic [3:0]  spr_size_t;   // tiles minus one
    typedef logic [6:0]  palette_t;
    typedef logic [14:0] tile_t;
    typedef logic [15:0] tile_offs_t;  // byte offset into sprite gfx
    typedef logic [31:0] slice_t;      // 8 pixels of 4 bits

    // {priority, palette, code}
    typedef logic [14:0] pixel_t;

    // {sprite index, word number}
    typedef logic [7:0]  ram_addr_t;
    typedef logic [15:0] ram_word_t;

    typedef enum logic [2:0] {
        SCAN_IDLE, SCAN_W0, SCAN_W3, SCAN_CHK, SCAN_PUSH
    } scan_state_t;

    typedef enum logic [2:0] {
        DRAW_IDLE, DRAW_ATTR, DRAW_SET, DRAW_REQ, DRAW_RSP, DRAW_PIX
    } draw_state_t;

endpackage

// ==== verilog/obj_line_scan.sv ====
//********************
// sprite line scanner
// reads words 0 and 3 of every sprite entry and pushes
// the sprites that cross the requested line into the queue
//********************
`timescale 1ns/10ps
`include "obj_config.svh"

module obj_line_scan (
    input  logic                CLK96,
    input  logic                RESET96,
    input  logic                line_start_i,
    input  obj_pkg::pos_t       line_i,
    input  obj_pkg::ram_word_t  ram_data_i,
    input  logic                push_ready_i,
    output obj_pkg::ram_addr_t  ram_addr_o,
    output logic                push_valid_o,
    output obj_pkg::spr_idx_t   push_idx_o,
    output obj_pkg::pri_t       push_pri_o,
    output logic                scan_done_o
);

    obj_pkg::scan_state_t state_q;
    logic [6:0]           spr_cnt;   // one bit wider than the index
    obj_pkg::pos_t        line_q;
    logic                 active_q;
    obj_pkg::pri_t        pri_q;
    obj_pkg::pos_t        y_pos;
    logic [9:0]           y_end;
    logic                 hit;
    logic                 resolve;

    // word 0 on the first read of a sprite, word 3 on the second
    assign ram_addr_o = {spr_cnt[5:0], (state_q == obj_pkg::SCAN_W3) ? 2'd3 : 2'd0};

    // word 3 is on the data bus while in SCAN_CHK
    assign y_pos = ram_data_i[15:7];
    assign y_end = {1'b0, y_pos} + {2'b00, {1'b0, ram_data_i[3:0]} + 5'd1, 3'b000};
    assign hit   = active_q && (line_q >= y_pos) && ({1'b0, line_q} < y_end);

    assign resolve = ((state_q == obj_pkg::SCAN_CHK) && !hit) ||
                     ((state_q == obj_pkg::SCAN_PUSH) && push_ready_i);

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            state_q      <= obj_pkg::SCAN_IDLE;
            spr_cnt      <= '0;
            line_q       <= '0;
            active_q     <= 1'b0;
            pri_q        <= '0;
            push_valid_o <= 1'b0;
            push_idx_o   <= '0;
            push_pri_o   <= '0;
            scan_done_o  <= 1'b0;
        end else begin
            scan_done_o <= 1'b0;
            case (state_q)
                obj_pkg::SCAN_IDLE: begin
                    if (line_start_i) begin
                        line_q  <= line_i;
                        spr_cnt <= '0;
                        state_q <= obj_pkg::SCAN_W0;
                    end
                end
                obj_pkg::SCAN_W0: state_q <= obj_pkg::SCAN_W3;
                obj_pkg::SCAN_W3: begin
                    active_q <= ram_data_i[15];     // word 0 arrives here
                    pri_q    <= ram_data_i[11:8];
                    state_q  <= obj_pkg::SCAN_CHK;
                end
                obj_pkg::SCAN_CHK: begin
                    if (hit) begin
                        push_valid_o <= 1'b1;
                        push_idx_o   <= spr_cnt[5:0];
                        push_pri_o   <= pri_q;
                        state_q      <= obj_pkg::SCAN_PUSH;
                    end
                end
                obj_pkg::SCAN_PUSH: begin
                    if (push_ready_i) push_valid_o <= 1'b0;   // hold until taken
                end
                default: state_q <= obj_pkg::SCAN_IDLE;
            endcase

            if (resolve) begin
                if (spr_cnt == 7'(`OBJ_SPRITES - 1)) begin
                    scan_done_o <= 1'b1;
                    state_q     <= obj_pkg::SCAN_IDLE;
                end else begin
                    spr_cnt <= spr_cnt + 7'd1;
                    state_q <= obj_pkg::SCAN_W0;
                end
            end
        end
    end

    a_spr_cnt_range: assert property (@(posedge CLK96) disable iff (RESET96)
        (state_q != obj_pkg::SCAN_IDLE) |-> (spr_cnt < `OBJ_SPRITES));

endmodule

// ==== verilog/obj_pri_queue.sv ====
//********************
// sprite priority queue
// files sprite indices into per-priority buckets during the
// scan, then hands them out lowest priority first
//********************
`timescale 1ns/10ps
`include "obj_config.svh"

module obj_pri_queue (
    input  logic               CLK96,
    input  logic               RESET96,
    input  logic               line_start_i,
    input  logic               push_valid_i,
    input  obj_pkg::spr_idx_t  push_idx_i,
    input  obj_pkg::pri_t      push_pri_i,
    input  logic               scan_done_i,
    input  logic               pop_ready_i,
    output logic               push_ready_o,
    output logic               pop_valid_o,
    output obj_pkg::spr_idx_t  pop_idx_o,
    output logic               queue_empty_o
);

    logic                        filling;
    logic                        draining;
    logic [6:0]                  cnt [`OBJ_PRIORITIES];
    logic [`OBJ_PRIORITIES-1:0]  pending;   // buckets with entries left
    obj_pkg::spr_idx_t           idx_mem [`OBJ_PRIORITIES * `OBJ_SPRITES];
    obj_pkg::spr_idx_t           rd_ptr;
    obj_pkg::pri_t               cur_pri;
    logic                        push_fire;
    logic                        pop_fire;
    logic                        last_in_bucket;

    // lowest pending bucket wins
    always_comb begin
        cur_pri = '0;
        for (int p = `OBJ_PRIORITIES - 1; p >= 0; p--) begin
            if (pending[p]) cur_pri = obj_pkg::pri_t'(p);
        end
    end

    assign push_ready_o   = filling;
    assign push_fire      = push_valid_i && filling;
    assign pop_fire       = draining && pop_ready_i && !pop_valid_o && (|pending);
    assign last_in_bucket = ({1'b0, rd_ptr} + 7'd1) == cnt[cur_pri];
    assign queue_empty_o  = draining && !(|pending) && !pop_valid_o;

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            filling     <= 1'b0;
            draining    <= 1'b0;
            pending     <= '0;
            rd_ptr      <= '0;
            pop_valid_o <= 1'b0;
            for (int p = 0; p < `OBJ_PRIORITIES; p++) cnt[p] <= '0;
        end else begin
            pop_valid_o <= pop_fire;    // index comes out of the RAM next cycle
            if (line_start_i) begin
                filling  <= 1'b1;
                draining <= 1'b0;
                pending  <= '0;
                rd_ptr   <= '0;
                for (int p = 0; p < `OBJ_PRIORITIES; p++) cnt[p] <= '0;
            end else begin
                if (push_fire) begin
                    cnt[push_pri_i]     <= cnt[push_pri_i] + 7'd1;
                    pending[push_pri_i] <= 1'b1;
                end
                if (scan_done_i) begin
                    filling  <= 1'b0;
                    draining <= 1'b1;
                end
                if (pop_fire) begin
                    if (last_in_bucket) begin
                        pending[cur_pri] <= 1'b0;
                        rd_ptr           <= '0;
                    end else begin
                        rd_ptr <= rd_ptr + 6'd1;
                    end
                end
            end
        end
    end

    always_ff @(posedge CLK96) begin
        if (push_fire) idx_mem[{push_pri_i, cnt[push_pri_i][5:0]}] <= push_idx_i;
        if (pop_fire) pop_idx_o <= idx_mem[{cur_pri, rd_ptr}];
    end

    // the scanner must be finished before the drain starts
    a_no_late_push: assert property (@(posedge CLK96) disable iff (RESET96)
        draining |-> !push_valid_i);

endmodule

// ==== verilog/obj_tile_draw.sv ====
//********************
// sprite draw sequencer
// reads the attributes of each queued sprite, fetches its tile
// slices from graphics ROM and writes the pixels to the line buffer
//********************
`timescale 1ns/10ps
`include "obj_config.svh"

module obj_tile_draw (
    input  logic                CLK96,
    input  logic                RESET96,
    input  logic                line_start_i,
    input  obj_pkg::pos_t       line_i,
    input  logic                pop_valid_i,
    input  obj_pkg::spr_idx_t   pop_idx_i,
    input  logic                queue_empty_i,
    input  obj_pkg::ram_word_t  ram_data_i,
    input  logic                gfx_req_ready_i,
    input  logic                gfx_rsp_valid_i,
    input  obj_pkg::slice_t     gfx_rsp_data_i,
    output logic                pop_ready_o,
    output obj_pkg::ram_addr_t  ram_addr_o,
    output logic                gfx_req_valid_o,
    output obj_pkg::tile_t      gfx_tile_o,
    output obj_pkg::tile_offs_t gfx_offs_o,
    output logic                wr_en_o,
    output obj_pkg::pos_t       wr_addr_o,
    output obj_pkg::pixel_t     wr_pixel_o,
    output logic                busy_o
);

    obj_pkg::draw_state_t state_q;
    obj_pkg::pos_t        line_q;
    obj_pkg::spr_idx_t    spr_idx;
    logic [2:0]           word_cnt;
    // attributes of the sprite being drawn
    logic                 xflip_q;
    obj_pkg::pri_t        pri_q;
    obj_pkg::palette_t    pal_q;
    obj_pkg::pos_t        x_q;
    obj_pkg::pos_t        y_q;
    obj_pkg::spr_size_t   xsize_q;
    obj_pkg::spr_size_t   col;
    obj_pkg::slice_t      slice_q;
    logic [2:0]           pix_t;
    obj_pkg::pos_t        r;
    obj_pkg::tile_offs_t  row_offs;
    obj_pkg::spr_size_t   col_eff;
    logic [2:0]           t_eff;
    logic [9:0]           px;
    logic [3:0]           nib;

    assign pop_ready_o = busy_o && (state_q == obj_pkg::DRAW_IDLE);
    assign ram_addr_o  = {spr_idx, word_cnt[1:0]};

    // offset of column 0 for the current row of the sprite
    assign r        = line_q - y_q;
    assign row_offs = obj_pkg::tile_offs_t'(r[8:3])
                    * obj_pkg::tile_offs_t'({1'b0, xsize_q} + 5'd1)
                    * obj_pkg::tile_offs_t'(`OBJ_TILE_BYTES)
                    + obj_pkg::tile_offs_t'(r[2:0]) * obj_pkg::tile_offs_t'(`OBJ_ROW_BYTES);

    // mirrored placement walks columns and nibbles backwards
    assign col_eff = xflip_q ? xsize_q - col : col;
    assign t_eff   = xflip_q ? ~pix_t : pix_t;
    assign px      = {1'b0, x_q} + {3'b000, col_eff, 3'b000} + {7'd0, t_eff};
    assign nib     = slice_q[{pix_t, 2'b00} +: 4];

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            state_q         <= obj_pkg::DRAW_IDLE;
            busy_o          <= 1'b0;
            gfx_req_valid_o <= 1'b0;
            wr_en_o         <= 1'b0;
            word_cnt        <= '0;
            col             <= '0;
            pix_t           <= '0;
        end else begin
            wr_en_o <= 1'b0;
            if (line_start_i) begin
                busy_o <= 1'b1;
                line_q <= line_i;
            end else if (queue_empty_i && state_q == obj_pkg::DRAW_IDLE) begin
                busy_o <= 1'b0;
            end

            case (state_q)
                obj_pkg::DRAW_IDLE: begin
                    if (pop_valid_i) begin
                        spr_idx  <= pop_idx_i;
                        word_cnt <= '0;
                        state_q  <= obj_pkg::DRAW_ATTR;
                    end
                end
                obj_pkg::DRAW_ATTR: begin
                    word_cnt <= word_cnt + 3'd1;
                    case (word_cnt)  // data lags the address by one
                        3'd1: begin
                            xflip_q <= ram_data_i[12];
                            pri_q   <= ram_data_i[11:8];
                            pal_q   <= ram_data_i[6:0];
                        end
                        3'd2: gfx_tile_o <= ram_data_i[14:0];
                        3'd3: begin
                            x_q     <= ram_data_i[15:7];
                            xsize_q <= ram_data_i[3:0];
                        end
                        3'd4: begin
                            y_q     <= ram_data_i[15:7];
                            state_q <= obj_pkg::DRAW_SET;
                        end
                        default: ;
                    endcase
                end
                obj_pkg::DRAW_SET: begin
                    gfx_req_valid_o <= 1'b1;
                    gfx_offs_o      <= row_offs;
                    col             <= '0;
                    state_q         <= obj_pkg::DRAW_REQ;
                end
                obj_pkg::DRAW_REQ: begin
                    if (gfx_req_ready_i) begin
                        gfx_req_valid_o <= 1'b0;
                        state_q         <= obj_pkg::DRAW_RSP;
                    end
                end
                obj_pkg::DRAW_RSP: begin
                    if (gfx_rsp_valid_i) begin
                        slice_q <= gfx_rsp_data_i;
                        pix_t   <= '0;
                        state_q <= obj_pkg::DRAW_PIX;
                    end
                end
                obj_pkg::DRAW_PIX: begin
                    wr_en_o    <= (nib != 4'd0) && (px < `OBJ_LINE_W);  // code 0 is blank
                    wr_addr_o  <= px[8:0];
                    wr_pixel_o <= {pri_q, pal_q, nib};
                    pix_t      <= pix_t + 3'd1;
                    if (pix_t == 3'(`OBJ_SLICE_PIX - 1)) begin
                        if (col == xsize_q) begin
                            state_q <= obj_pkg::DRAW_IDLE;
                        end else begin
                            col             <= col + 4'd1;
                            gfx_req_valid_o <= 1'b1;
                            gfx_offs_o      <= gfx_offs_o + 16'(`OBJ_TILE_BYTES);
                            state_q         <= obj_pkg::DRAW_REQ;
                        end
                    end
                end
                default: state_q <= obj_pkg::DRAW_IDLE;
            endcase
        end
    end

    a_req_stable: assert property (@(posedge CLK96) disable iff (RESET96)
        (gfx_req_valid_o && !gfx_req_ready_i) |=>
            (gfx_req_valid_o && $stable(gfx_tile_o) && $stable(gfx_offs_o)));

    a_wr_in_line: assert property (@(posedge CLK96) disable iff (RESET96)
        wr_en_o |-> (wr_addr_o < `OBJ_LINE_W));

endmodule

// ==== verilog/obj_line_buf.sv ====
//********************
// sprite line buffer
// one bank is drawn while the other is shown, and each
// entry is cleared as it is read out
//********************
`timescale 1ns/10ps
`include "obj_config.svh"

module obj_line_buf (
    input  logic             CLK96,
    input  logic             RESET96,
    input  logic             line_start_i,
    input  logic             wr_en_i,
    input  obj_pkg::pos_t    wr_addr_i,
    input  obj_pkg::pixel_t  wr_pixel_i,
    input  logic             pixel_cen_i,
    input  obj_pkg::pos_t    h_i,
    output obj_pkg::pixel_t  pixel_o
);

    obj_pkg::pixel_t mem [2 * `OBJ_BUF_DEPTH];
    logic            bank_sel;   // bank being drawn
    logic [9:0]      wr_a;
    logic [9:0]      rd_a;

    assign wr_a = {bank_sel, wr_addr_i};
    assign rd_a = {~bank_sel, h_i};

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            bank_sel <= 1'b0;
            pixel_o  <= '0;
        end else begin
            if (line_start_i) bank_sel <= ~bank_sel;
            if (pixel_cen_i) pixel_o <= mem[rd_a];
        end
    end

    always_ff @(posedge CLK96) begin
        if (wr_en_i) mem[wr_a] <= wr_pixel_i;
        if (pixel_cen_i) mem[rd_a] <= '0;   // ready for the next line drawn here
    end

endmodule

// ==== verilog/obj_engine.sv ====
//********************
// sprite layer engine
// scanner, priority queue, draw unit and line buffer
//********************
`timescale 1ns/10ps

module obj_engine (
    input  logic                CLK96,
    input  logic                RESET96,
    input  logic                line_start_i,
    input  obj_pkg::pos_t       line_i,
    input  logic                pixel_cen_i,
    input  obj_pkg::pos_t       h_i,
    output obj_pkg::ram_addr_t  scan_ram_addr_o,
    input  obj_pkg::ram_word_t  scan_ram_data_i,
    output obj_pkg::ram_addr_t  draw_ram_addr_o,
    input  obj_pkg::ram_word_t  draw_ram_data_i,
    output logic                gfx_req_valid_o,
    input  logic                gfx_req_ready_i,
    output obj_pkg::tile_t      gfx_tile_o,
    output obj_pkg::tile_offs_t gfx_offs_o,
    input  logic                gfx_rsp_valid_i,
    input  obj_pkg::slice_t     gfx_rsp_data_i,
    output obj_pkg::pixel_t     pixel_o,
    output logic                busy_o
);

    logic              line_go;
    logic              push_valid, push_ready, scan_done;
    obj_pkg::spr_idx_t push_idx, pop_idx;
    obj_pkg::pri_t     push_pri;
    logic              pop_valid, pop_ready, queue_empty;
    logic              wr_en;
    obj_pkg::pos_t     wr_addr;
    obj_pkg::pixel_t   wr_pixel;

    // a new line only starts when the previous one is finished
    assign line_go = line_start_i && !busy_o;

    obj_line_scan i_scan (
        .CLK96, .RESET96,
        .line_start_i(line_go), .line_i,
        .ram_data_i(scan_ram_data_i), .push_ready_i(push_ready),
        .ram_addr_o(scan_ram_addr_o), .push_valid_o(push_valid),
        .push_idx_o(push_idx), .push_pri_o(push_pri), .scan_done_o(scan_done)
    );

    obj_pri_queue i_queue (
        .CLK96, .RESET96,
        .line_start_i(line_go),
        .push_valid_i(push_valid), .push_idx_i(push_idx), .push_pri_i(push_pri),
        .scan_done_i(scan_done), .pop_ready_i(pop_ready),
        .push_ready_o(push_ready), .pop_valid_o(pop_valid),
        .pop_idx_o(pop_idx), .queue_empty_o(queue_empty)
    );

    obj_tile_draw i_draw (
        .CLK96, .RESET96,
        .line_start_i(line_go), .line_i,
        .pop_valid_i(pop_valid), .pop_idx_i(pop_idx), .queue_empty_i(queue_empty),
        .ram_data_i(draw_ram_data_i),
        .gfx_req_ready_i, .gfx_rsp_valid_i, .gfx_rsp_data_i,
        .pop_ready_o(pop_ready), .ram_addr_o(draw_ram_addr_o),
        .gfx_req_valid_o, .gfx_tile_o, .gfx_offs_o,
        .wr_en_o(wr_en), .wr_addr_o(wr_addr), .wr_pixel_o(wr_pixel),
        .busy_o
    );

    // every line start swaps banks, even during a render
    obj_line_buf i_line_buf (
        .CLK96, .RESET96,
        .line_start_i,
        .wr_en_i(wr_en), .wr_addr_i(wr_addr), .wr_pixel_i(wr_pixel),
        .pixel_cen_i, .h_i,
        .pixel_o
    );

endmodule

// ==== testbench/tb_obj_engine.sv ====
//********************
// sprite engine testbench
// renders table-driven scenes through the whole engine with
// random ROM back-pressure and checks every pixel against a
// model of the sprite rules
//********************
`timescale 1ns/10ps
`include "obj_config.svh"

module tb_obj_engine;

    localparam int ROWS = 11;

    logic                CLK96 = 1'b0;
    logic                RESET96 = 1'b1;
    logic                line_start_i = 1'b0;
    obj_pkg::pos_t       line_i = '0;
    logic                pixel_cen_i = 1'b0;
    obj_pkg::pos_t       h_i = '0;
    obj_pkg::ram_addr_t  scan_ram_addr_o;
    obj_pkg::ram_word_t  scan_ram_data_i = '0;
    obj_pkg::ram_addr_t  draw_ram_addr_o;
    obj_pkg::ram_word_t  draw_ram_data_i = '0;
    logic                gfx_req_valid_o;
    logic                gfx_req_ready_i = 1'b0;
    obj_pkg::tile_t      gfx_tile_o;
    obj_pkg::tile_offs_t gfx_offs_o;
    logic                gfx_rsp_valid_i = 1'b0;
    obj_pkg::slice_t     gfx_rsp_data_i = '0;
    obj_pkg::pixel_t     pixel_o;
    logic                busy_o;

    obj_pkg::ram_word_t  spr_ram [256];
    obj_pkg::ram_addr_t  scan_addr_q = '0;
    obj_pkg::ram_addr_t  draw_addr_q = '0;
    obj_pkg::pixel_t     exp_line [`OBJ_LINE_W];
    integer              seed = 32'hff92;
    int                  errors = 0;
    int                  checks = 0;
    logic                accept_q = 1'b0;     // ROM took a request last edge
    obj_pkg::tile_t      req_tile_q = '0;
    obj_pkg::tile_offs_t req_offs_q = '0;
    int                  rsp_wait = 0;

    // per row the line, the sprite RAM scene and a blank flag
    int row_line  [ROWS] = '{0, 40, 47, 55, 39, 56, 13, 62, 85, 120, 121};
    int row_scene [ROWS] = '{0, 1, 1, 1, 1, 1, 2, 3, 4, 5, 5};
    int row_blank [ROWS] = '{1, 0, 0, 0, 1, 1, 0, 0, 0, 0, 0};

    obj_engine i_dut (.*);

    always #2 CLK96 = ~CLK96;

    // sprite RAM model with one cycle of read latency on both ports
    always @(posedge CLK96) begin
        scan_addr_q <= scan_ram_addr_o;
        draw_addr_q <= draw_ram_addr_o;
    end

    always @(negedge CLK96) begin
        scan_ram_data_i = spr_ram[scan_addr_q];
        draw_ram_data_i = spr_ram[draw_addr_q];
    end

    always @(posedge CLK96) begin
        accept_q <= gfx_req_valid_o && gfx_req_ready_i;
        if (gfx_req_valid_o && gfx_req_ready_i) begin
            req_tile_q <= gfx_tile_o;
            req_offs_q <= gfx_offs_o;
        end
    end

    // graphics ROM with random ready and 1 to 4 cycles of latency
    always @(negedge CLK96) begin
        logic [31:0] rnd;
        rnd = $random(seed);
        gfx_req_ready_i = rnd[0];
        gfx_rsp_valid_i = 1'b0;
        if (accept_q) rsp_wait = 1 + rnd[2:1];
        if (rsp_wait > 0) begin
            rsp_wait--;
            if (rsp_wait == 0) begin
                gfx_rsp_valid_i = 1'b1;
                gfx_rsp_data_i  = rom_word(req_tile_q, req_offs_q);
            end
        end
    end

    // ROM contents hashed from the whole tile and offset with nibbles 2 and 5 blank
    function automatic obj_pkg::slice_t rom_word(input int tile, input int offs);
        logic [31:0] h;
        h = (32'(tile) << 16) ^ 32'(offs);
        h = h * 32'h9e3779b1;
        h = h ^ (h >> 15);
        h = h * 32'h85ebca6b;
        h = h ^ (h >> 13);
        h[11:8]  = 4'h0;
        h[23:20] = 4'h0;
        return h;
    endfunction

    task automatic place_sprite(input int idx, input int act, input int flip, input int pri,
                                input int pal, input int tile, input int x, input int xs,
                                input int y, input int ys);
        spr_ram[idx*4 + 0] = 16'((act << 15) | (flip << 12) | (pri << 8) | pal);
        spr_ram[idx*4 + 1] = 16'(tile);
        spr_ram[idx*4 + 2] = 16'((x << 7) | xs);
        spr_ram[idx*4 + 3] = 16'((y << 7) | ys);
    endtask

    // every entry starts inactive with address-dependent junk in the other fields
    task automatic fill_scene(input int scene);
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] r3;
        for (int a = 0; a < 256; a++) begin
            spr_ram[a] = 16'(a * 40503 + 4660) & 16'h7fff;
        end
        case (scene)
            1: place_sprite(5, 1, 0, 3, 'h12, 'h0040, 20, 1, 40, 1);
            2: place_sprite(9, 1, 1, 2, 'h33, 'h0123, 100, 2, 10, 0);
            3: begin
                place_sprite(10, 1, 0, 5, 'h05, 'h0200, 50, 1, 60, 0);
                place_sprite(3, 1, 0, 7, 'h07, 'h0300, 54, 1, 60, 0);   // higher pri, lower index
                place_sprite(20, 1, 1, 4, 'h14, 'h0400, 150, 1, 58, 0);
                place_sprite(21, 1, 0, 4, 'h15, 'h0500, 153, 1, 60, 0);
            end
            4: begin
                place_sprite(30, 1, 0, 6, 'h1e, 'h0600, 300, 3, 80, 2);  // runs past x 319
                place_sprite(31, 1, 1, 1, 'h1f, 'h0700, 315, 0, 84, 0);
                place_sprite(32, 0, 0, 9, 'h20, 'h0800, 200, 2, 80, 2);  // inactive
            end
            5: begin
                for (int k = 0; k < 16; k++) begin
                    r1 = $random(seed);
                    r2 = $random(seed);
                    r3 = $random(seed);
                    place_sprite(r1[5:0], 1, r1[6], r1[10:7], r1[17:11], r2[24:10],
                                 r2[8:0] % 330, r2[26:25], 60 + r3[6:0], r3[9:7]);
                end
            end
            default: ;
        endcase
    endtask

    // expected line built lowest priority first and by ascending index so later writes win
    task automatic build_expected(input int line);
        obj_pkg::ram_word_t w0;
        obj_pkg::ram_word_t w1;
        obj_pkg::ram_word_t w2;
        obj_pkg::ram_word_t w3;
        obj_pkg::slice_t    s;
        logic [3:0]         n;
        int                 x, y, xs, ys, r, offs, px;
        foreach (exp_line[h]) exp_line[h] = '0;
        for (int p = 0; p < `OBJ_PRIORITIES; p++) begin
            for (int i = 0; i < `OBJ_SPRITES; i++) begin
                w0 = spr_ram[i*4];
                w1 = spr_ram[i*4 + 1];
                w2 = spr_ram[i*4 + 2];
                w3 = spr_ram[i*4 + 3];
                x  = w2[15:7];
                xs = w2[3:0];
                y  = w3[15:7];
                ys = w3[3:0];
                if (w0[15] && w0[11:8] == p && line >= y && line < y + 8 * (ys + 1)) begin
                    r = line - y;
                    for (int c = 0; c <= xs; c++) begin
                        offs = (r / 8) * (xs + 1) * `OBJ_TILE_BYTES
                             + (r % 8) * `OBJ_ROW_BYTES + c * `OBJ_TILE_BYTES;
                        s = rom_word(w1[14:0], offs);
                        for (int t = 0; t < 8; t++) begin
                            n  = s[4*t +: 4];
                            px = w0[12] ? x + 8 * (xs - c) + 7 - t : x + 8 * c + t;
                            if (n != 0 && px < `OBJ_LINE_W) begin
                                exp_line[px] = {w0[11:8], w0[6:0], n};
                            end
                        end
                    end
                end
            end
        end
    endtask

    // one line start pulse, then wait for the render to finish
    task automatic start_line(input int line);
        @(negedge CLK96);
        line_start_i = 1'b1;
        line_i       = 9'(line);
        @(negedge CLK96);
        line_start_i = 1'b0;
        assert (busy_o) else begin
            errors++;
            $display("busy_o did not rise after line_start_i for line %0d", line);
        end
        while (busy_o) @(negedge CLK96);
    endtask

    // mode 0 only clears the shown bank, 1 checks the expected line, 2 checks zeros
    task automatic sweep_line(input int mode);
        obj_pkg::pixel_t want;
        for (int h = 0; h <= `OBJ_LINE_W; h++) begin
            @(negedge CLK96);
            if (h > 0 && mode != 0) begin
                want = (mode == 1) ? exp_line[h-1] : '0;
                checks++;
                assert (pixel_o === want) else begin
                    errors++;
                    $display("error pixel_o at h=%0d: got %h, expected %h", h - 1, pixel_o, want);
                end
            end
            pixel_cen_i = (h < `OBJ_LINE_W);
            h_i         = 9'(h);
        end
    endtask

    initial begin
        fill_scene(0);
        repeat (4) @(negedge CLK96);
        RESET96 = 1'b0;
        @(negedge CLK96);
        checks += 3;
        assert (busy_o === 1'b0) else begin
            errors++;
            $display("error busy_o after reset: got %h, expected 0", busy_o);
        end
        assert (gfx_req_valid_o === 1'b0) else begin
            errors++;
            $display("error gfx_req_valid_o after reset: got %h, expected 0", gfx_req_valid_o);
        end
        assert (pixel_o === '0) else begin
            errors++;
            $display("error pixel_o after reset: got %h, expected 0", pixel_o);
        end

        // read both banks once so that they start out clear
        sweep_line(0);
        start_line(0);
        sweep_line(0);

        for (int i = 0; i < ROWS; i++) begin
            fill_scene(row_scene[i]);
            if (row_blank[i]) begin
                foreach (exp_line[h]) exp_line[h] = '0;
            end else begin
                build_expected(row_line[i]);
            end
            start_line(row_line[i]);   // render into the draw bank
            start_line(row_line[i]);   // swap so the rendered bank is shown
            sweep_line(1);
            sweep_line(2);             // cleared by the first read
        end

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        #(ROWS * 40000);
        $display("timeout, the run did not finish within %0d ns", ROWS * 40000);
        $display(">>> FAIL");
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+verilog
verilog/obj_pkg.sv
verilog/obj_line_scan.sv
verilog/obj_pri_queue.sv
verilog/obj_tile_draw.sv
verilog/obj_line_buf.sv
verilog/obj_engine.sv
testbench/tb_obj_engine.sv
